// ==== swc_cfg.svh ====
// switch core configuration: port count, data width, queue depths and frame length limit
`ifndef SWC_CFG_SVH
`define SWC_CFG_SVH

// --------------------
// port structure
// --------------------
`define SWC_NUM_PORTS 4
`define SWC_DATA_WIDTH 16

// --------------------
// queueing
// --------------------
// words held by each input FIFO and each output FIFO
`define SWC_FRAME_FIFO_DEPTH 32
// routing decisions queued ahead of their frames
`define SWC_RTU_FIFO_DEPTH 4

// longest legal frame in words, never more than SWC_FRAME_FIFO_DEPTH
`define SWC_MAX_FRAME_WORDS 16

`endif

// ==== swc_pkg.sv ====
// switch core shared types for fabric words, port masks and routing decisions
`include "swc_cfg.svh"

package swc_pkg;

   // --------------------
   // destination set
   // --------------------
   // one bit per output port, bit p selects port p
   typedef logic [`SWC_NUM_PORTS-1:0] port_mask_t;

   // --------------------
   // fabric word
   // --------------------
   // data word plus end-of-frame mark, start-of-frame is rebuilt at the output
   typedef struct packed {
      logic [`SWC_DATA_WIDTH-1:0] data;
      logic                       eof;
   } fab_word_t;

   // --------------------
   // routing decision
   // --------------------
   // an empty mask is treated the same as a set drop bit
   typedef struct packed {
      port_mask_t mask;
      logic       drop;
   } rtu_rsp_t;

endpackage

// ==== swc_fifo.sv ====
// synchronous valid/ready FIFO, circular buffer with occupancy count and any payload type
`timescale 1ns/1ns

module swc_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic clk,
   input  logic rst_n_i,
   input  logic wr_valid_i,
   output logic wr_ready_o,
   input  T     wr_data_i,
   output logic rd_valid_o,
   input  logic rd_ready_i,
   output T     rd_data_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T              mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          do_wr;
   logic          do_rd;

   // pointer wrap also covers depths that are not a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign wr_ready_o = (count_q != CW'(DEPTH));
   assign rd_valid_o = (count_q != '0);
   assign do_wr      = wr_valid_i & wr_ready_o;
   assign do_rd      = rd_valid_o & rd_ready_i;

   // head of queue is always visible on the read side
   assign rd_data_o = mem[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (do_rd)
            rd_ptr_q <= next_ptr(rd_ptr_q);
         // simultaneous push and pop leave the count unchanged
         if (do_wr && !do_rd)
            count_q <= count_q + 1'b1;
         else if (!do_wr && do_rd)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// ==== swc_input_block.sv ====
// switch input port: frame storage, routing decision queue, dispatch or discard per frame
`timescale 1ns/1ns
`include "swc_cfg.svh"

module swc_input_block import swc_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic       fab_valid_i,
   output logic       fab_ready_o,
   input  fab_word_t  fab_word_i,
   input  logic       rtu_valid_i,
   output logic       rtu_ready_o,
   input  rtu_rsp_t   rtu_rsp_i,
   output logic       req_o,
   input  logic       gnt_i,
   input  logic       bus_ready_i,
   output fab_word_t  bus_word_o,
   output port_mask_t bus_mask_o
);

   localparam int FCW = $clog2(`SWC_FRAME_FIFO_DEPTH + 1);

   fab_word_t      head_word;
   rtu_rsp_t       head_rsp;
   logic           word_valid;
   logic           word_pop;
   logic           rsp_valid;
   logic           rsp_pop;
   logic           frame_ready;
   logic           discard;
   logic           send_word;
   logic           drain_word;
   logic           frame_in;
   logic           frame_out;
   logic [FCW-1:0] frame_cnt_q;

   // --------------------
   // storage
   // --------------------
   swc_fifo #(
      .T     (fab_word_t),
      .DEPTH (`SWC_FRAME_FIFO_DEPTH)
   ) i_frame_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (fab_valid_i),
      .wr_ready_o (fab_ready_o),
      .wr_data_i  (fab_word_i),
      .rd_valid_o (word_valid),
      .rd_ready_i (word_pop),
      .rd_data_o  (head_word)
   );

   swc_fifo #(
      .T     (rtu_rsp_t),
      .DEPTH (`SWC_RTU_FIFO_DEPTH)
   ) i_rtu_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (rtu_valid_i),
      .wr_ready_o (rtu_ready_o),
      .wr_data_i  (rtu_rsp_i),
      .rd_valid_o (rsp_valid),
      .rd_ready_i (rsp_pop),
      .rd_data_o  (head_rsp)
   );

   // --------------------
   // frame decision
   // --------------------
   // frames leave in order, so any complete frame means the head one is complete
   assign frame_ready = (frame_cnt_q != '0) & rsp_valid;
   assign discard     = head_rsp.drop | (head_rsp.mask == '0);
   assign req_o       = frame_ready & ~discard;

   // granted words go out on the bus, discarded words drain on their own
   assign send_word  = req_o & gnt_i & bus_ready_i;
   assign drain_word = frame_ready & discard;
   assign word_pop   = word_valid & (send_word | drain_word);

   assign frame_in  = fab_valid_i & fab_ready_o & fab_word_i.eof;
   assign frame_out = word_pop & head_word.eof;

   // the decision is retired together with the last word of its frame
   assign rsp_pop = frame_out;

   assign bus_word_o = head_word;
   assign bus_mask_o = head_rsp.mask;

   // complete frames currently stored
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         frame_cnt_q <= '0;
      else if (frame_in && !frame_out)
         frame_cnt_q <= frame_cnt_q + 1'b1;
      else if (!frame_in && frame_out)
         frame_cnt_q <= frame_cnt_q - 1'b1;
   end

endmodule

// ==== swc_xbar_arbiter.sv ====
// crossbar arbiter: round-robin frame grant and mux of the granted input onto the shared bus
`timescale 1ns/1ns
`include "swc_cfg.svh"

module swc_xbar_arbiter import swc_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  port_mask_t                       req_i,
   output port_mask_t                       gnt_o,
   input  fab_word_t  [`SWC_NUM_PORTS-1:0] in_words_i,
   input  port_mask_t [`SWC_NUM_PORTS-1:0] in_masks_i,
   input  port_mask_t                       out_ready_i,
   output logic                             bus_valid_o,
   output logic                             bus_ready_o,
   output fab_word_t                        bus_word_o,
   output port_mask_t                       bus_mask_o
);

   localparam int N  = `SWC_NUM_PORTS;
   localparam int PW = (N > 1) ? $clog2(N) : 1;

   port_mask_t    gnt_q;
   port_mask_t    next_gnt;
   logic [PW-1:0] last_q;
   logic [PW-1:0] next_last;
   logic          frame_done;

   // --------------------
   // round robin
   // --------------------
   // search starts just after the last winner and wraps around
   always_comb
   begin
      int idx;
      next_gnt  = '0;
      next_last = last_q;
      for (int i = 1; i <= N; i++)
      begin
         idx = (int'(last_q) + i) % N;
         if (req_i[idx] && next_gnt == '0)
         begin
            next_gnt[idx] = 1'b1;
            next_last     = PW'(idx);
         end
      end
   end

   // --------------------
   // bus mux
   // --------------------
   always_comb
   begin
      bus_word_o = '0;
      bus_mask_o = '0;
      for (int p = 0; p < N; p++)
      begin
         if (gnt_q[p])
         begin
            bus_word_o = in_words_i[p];
            bus_mask_o = in_masks_i[p];
         end
      end
   end

   assign bus_valid_o = |(gnt_q & req_i);

   // every named output must have room, unnamed ones do not matter
   assign bus_ready_o = &(out_ready_i | ~bus_mask_o);

   assign frame_done = bus_valid_o & bus_ready_o & bus_word_o.eof;
   assign gnt_o      = gnt_q;

   // grant is held until the last word of the frame has crossed the bus
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         gnt_q  <= '0;
         last_q <= PW'(N - 1);
      end
      else if (gnt_q != '0)
      begin
         if (frame_done)
            gnt_q <= '0;
      end
      else if (req_i != '0)
      begin
         gnt_q  <= next_gnt;
         last_q <= next_last;
      end
   end

endmodule

// ==== swc_output_block.sv ====
// switch output port: frame FIFO fed from the bus, start-of-frame rebuilt on the outgoing fabric
`timescale 1ns/1ns
`include "swc_cfg.svh"

module swc_output_block import swc_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       bus_valid_i,
   input  logic                       bus_sel_i,
   input  fab_word_t                  bus_word_i,
   output logic                       ready_o,
   output logic                       fab_valid_o,
   input  logic                       fab_ready_i,
   output logic [`SWC_DATA_WIDTH-1:0] fab_data_o,
   output logic                       fab_sof_o,
   output logic                       fab_eof_o
);

   fab_word_t out_word;
   logic      wr_en;
   logic      deliver;
   logic      sof_q;

   // bus_valid_i already carries the bus transfer condition
   assign wr_en = bus_valid_i & bus_sel_i;

   swc_fifo #(
      .T     (fab_word_t),
      .DEPTH (`SWC_FRAME_FIFO_DEPTH)
   ) i_out_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (wr_en),
      .wr_ready_o (ready_o),
      .wr_data_i  (bus_word_i),
      .rd_valid_o (fab_valid_o),
      .rd_ready_i (fab_ready_i),
      .rd_data_o  (out_word)
   );

   assign deliver = fab_valid_o & fab_ready_i;

   // --------------------
   // frame marks
   // --------------------
   // next word starts a frame once the previous one ended
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         sof_q <= 1'b1;
      else if (deliver)
         sof_q <= out_word.eof;
   end

   assign fab_data_o = out_word.data;
   assign fab_sof_o  = fab_valid_o & sof_q;
   assign fab_eof_o  = fab_valid_o & out_word.eof;

endmodule

// ==== swc_core.sv ====
// switch core top: input ports, crossbar arbiter and output ports joined by one shared bus
`timescale 1ns/1ns
`include "swc_cfg.svh"

module swc_core import swc_pkg::*;
(
   input  logic                                    clk,
   input  logic                                    rst_n_i,
   input  logic [`SWC_NUM_PORTS-1:0]               fab_in_valid_i,
   output logic [`SWC_NUM_PORTS-1:0]               fab_in_ready_o,
   input  logic [`SWC_NUM_PORTS*`SWC_DATA_WIDTH-1:0] fab_in_data_i,
   input  logic [`SWC_NUM_PORTS-1:0]               fab_in_eof_i,
   output logic [`SWC_NUM_PORTS-1:0]               fab_out_valid_o,
   input  logic [`SWC_NUM_PORTS-1:0]               fab_out_ready_i,
   output logic [`SWC_NUM_PORTS*`SWC_DATA_WIDTH-1:0] fab_out_data_o,
   output logic [`SWC_NUM_PORTS-1:0]               fab_out_sof_o,
   output logic [`SWC_NUM_PORTS-1:0]               fab_out_eof_o,
   input  logic [`SWC_NUM_PORTS-1:0]               rtu_valid_i,
   output logic [`SWC_NUM_PORTS-1:0]               rtu_ready_o,
   input  logic [`SWC_NUM_PORTS*`SWC_NUM_PORTS-1:0]  rtu_mask_i,
   input  logic [`SWC_NUM_PORTS-1:0]               rtu_drop_i
);

   localparam int N = `SWC_NUM_PORTS;
   localparam int W = `SWC_DATA_WIDTH;

   fab_word_t  [N-1:0] bus_words;
   port_mask_t [N-1:0] bus_masks;
   port_mask_t         req;
   port_mask_t         gnt;
   port_mask_t         out_ready;
   fab_word_t          bus_word;
   port_mask_t         bus_mask;
   logic               bus_valid;
   logic               bus_ready;
   logic               bus_xfer;

   // --------------------
   // input ports
   // --------------------
   for (genvar p = 0; p < N; p++)
   begin : g_in
      fab_word_t in_word;
      rtu_rsp_t  in_rsp;

      assign in_word.data = fab_in_data_i[p*W +: W];
      assign in_word.eof  = fab_in_eof_i[p];
      assign in_rsp.mask  = rtu_mask_i[p*N +: N];
      assign in_rsp.drop  = rtu_drop_i[p];

      swc_input_block i_input_block (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .fab_valid_i (fab_in_valid_i[p]),
         .fab_ready_o (fab_in_ready_o[p]),
         .fab_word_i  (in_word),
         .rtu_valid_i (rtu_valid_i[p]),
         .rtu_ready_o (rtu_ready_o[p]),
         .rtu_rsp_i   (in_rsp),
         .req_o       (req[p]),
         .gnt_i       (gnt[p]),
         .bus_ready_i (bus_ready),
         .bus_word_o  (bus_words[p]),
         .bus_mask_o  (bus_masks[p])
      );
   end

   // --------------------
   // crossbar
   // --------------------
   swc_xbar_arbiter i_xbar_arbiter (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .req_i       (req),
      .gnt_o       (gnt),
      .in_words_i  (bus_words),
      .in_masks_i  (bus_masks),
      .out_ready_i (out_ready),
      .bus_valid_o (bus_valid),
      .bus_ready_o (bus_ready),
      .bus_word_o  (bus_word),
      .bus_mask_o  (bus_mask)
   );

   // outputs write only when every named output takes the word
   assign bus_xfer = bus_valid & bus_ready;

   // --------------------
   // output ports
   // --------------------
   for (genvar p = 0; p < N; p++)
   begin : g_out
      swc_output_block i_output_block (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .bus_valid_i (bus_xfer),
         .bus_sel_i   (bus_mask[p]),
         .bus_word_i  (bus_word),
         .ready_o     (out_ready[p]),
         .fab_valid_o (fab_out_valid_o[p]),
         .fab_ready_i (fab_out_ready_i[p]),
         .fab_data_o  (fab_out_data_o[p*W +: W]),
         .fab_sof_o   (fab_out_sof_o[p]),
         .fab_eof_o   (fab_out_eof_o[p])
      );
   end

endmodule

// ==== tb_swc_core.sv ====
// switch core testbench with random frame traffic on every port and a per-flow reference model
`timescale 1ns/1ns
`include "swc_cfg.svh"

module tb_swc_core;

   localparam int N       = `SWC_NUM_PORTS;
   localparam int W       = `SWC_DATA_WIDTH;
   localparam int PB      = $clog2(N);
   localparam int SW      = W - PB;
   localparam int MAXW    = `SWC_MAX_FRAME_WORDS;
   localparam int FRAMES  = 40;
   localparam int TIMEOUT = 20000;

   logic           clk = 1'b0;
   logic           rst_n;
   logic           start = 1'b0;
   logic [N-1:0]   fab_out_ready;
   wire  [N-1:0]   fab_in_valid;
   wire  [N-1:0]   fab_in_ready;
   wire  [N*W-1:0] fab_in_data;
   wire  [N-1:0]   fab_in_eof;
   wire  [N-1:0]   fab_out_valid;
   wire  [N*W-1:0] fab_out_data;
   wire  [N-1:0]   fab_out_sof;
   wire  [N-1:0]   fab_out_eof;
   wire  [N-1:0]   rtu_valid;
   wire  [N-1:0]   rtu_ready;
   wire  [N*N-1:0] rtu_mask;
   wire  [N-1:0]   rtu_drop;
   wire  [N-1:0]   frames_sent;
   wire  [N-1:0]   rsps_sent;
   wire  [N-1:0]   sink_drained;

   // stimulus tables are filled before reset is released
   int           frm_len  [N][FRAMES];
   int           frm_gap  [N][FRAMES];
   int           rsp_gap  [N][FRAMES];
   logic [N-1:0] frm_mask [N][FRAMES];
   logic         frm_drop [N][FRAMES];
   logic [W-1:0] frm_word [N][FRAMES][MAXW];

   // reference model holds frame indices per source and destination in send order
   int exp_q [N][N][$];

   always #2 clk = ~clk;

   swc_core i_swc_core (
      .clk             (clk),
      .rst_n_i         (rst_n),
      .fab_in_valid_i  (fab_in_valid),
      .fab_in_ready_o  (fab_in_ready),
      .fab_in_data_i   (fab_in_data),
      .fab_in_eof_i    (fab_in_eof),
      .fab_out_valid_o (fab_out_valid),
      .fab_out_ready_i (fab_out_ready),
      .fab_out_data_o  (fab_out_data),
      .fab_out_sof_o   (fab_out_sof),
      .fab_out_eof_o   (fab_out_eof),
      .rtu_valid_i     (rtu_valid),
      .rtu_ready_o     (rtu_ready),
      .rtu_mask_i      (rtu_mask),
      .rtu_drop_i      (rtu_drop)
   );

   // --------------------
   // helpers
   // --------------------
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
   endtask

   task automatic start_sync();
      int cycles;
      cycles = 0;
      while (!start)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            fail_run("timeout while waiting for the stimulus to start");
      end
      #1;
   endtask

   task automatic idle_cycles(input int n);
      for (int g = 0; g < n; g++)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic hold_until_accepted(input int p, input bit is_rsp);
      int   cycles;
      logic taken;
      cycles = 0;
      taken  = 1'b0;
      while (!taken)
      begin
         // ready is settled by the falling edge and the transfer follows on the rising edge
         @(negedge clk);
         taken = is_rsp ? rtu_ready[p] : fab_in_ready[p];
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            fail_run($sformatf("timeout while input %0d did not accept a %s", p,
                               is_rsp ? "routing response" : "frame word"));
      end
      #1;
   endtask

   // --------------------
   // sources
   // --------------------
   for (genvar p = 0; p < N; p++)
   begin : g_src
      logic         in_valid;
      logic [W-1:0] in_data;
      logic         in_eof;
      logic         frm_done;
      logic         rsp_valid;
      logic [N-1:0] rsp_mask;
      logic         rsp_drop;
      logic         rsp_done;

      assign fab_in_valid[p]         = in_valid;
      assign fab_in_data[p*W +: W]   = in_data;
      assign fab_in_eof[p]           = in_eof;
      assign rtu_valid[p]            = rsp_valid;
      assign rtu_mask[p*N +: N]      = rsp_mask;
      assign rtu_drop[p]             = rsp_drop;
      assign frames_sent[p]          = frm_done;
      assign rsps_sent[p]            = rsp_done;

      // frame words with valid held for the whole frame
      initial
      begin
         in_valid = 1'b0;
         in_data  = '0;
         in_eof   = 1'b0;
         frm_done = 1'b0;
         start_sync();
         for (int i = 0; i < FRAMES; i++)
         begin
            idle_cycles(frm_gap[p][i]);
            for (int k = 0; k < frm_len[p][i]; k++)
            begin
               in_valid = 1'b1;
               in_data  = frm_word[p][i][k];
               in_eof   = (k == frm_len[p][i] - 1);
               hold_until_accepted(p, 1'b0);
            end
            in_valid = 1'b0;
            in_eof   = 1'b0;
         end
         frm_done = 1'b1;
      end

      // routing responses run on their own timeline
      initial
      begin
         rsp_valid = 1'b0;
         rsp_mask  = '0;
         rsp_drop  = 1'b0;
         rsp_done  = 1'b0;
         start_sync();
         for (int i = 0; i < FRAMES; i++)
         begin
            idle_cycles(rsp_gap[p][i]);
            rsp_valid = 1'b1;
            rsp_mask  = frm_mask[p][i];
            rsp_drop  = frm_drop[p][i];
            hold_until_accepted(p, 1'b1);
            rsp_valid = 1'b0;
         end
         rsp_done = 1'b1;
      end
   end

   // --------------------
   // sinks
   // --------------------
   for (genvar d = 0; d < N; d++)
   begin : g_sink
      int   rd_idx [N];
      int   src;
      int   frm;
      int   word_idx;
      logic drained;

      assign sink_drained[d] = drained;

      initial
      begin
         src      = 0;
         frm      = 0;
         word_idx = 0;
         drained  = 1'b1;
         for (int s = 0; s < N; s++)
            rd_idx[s] = 0;
         forever
         begin
            @(negedge clk);
            if (rst_n && fab_out_valid[d] && fab_out_ready[d])
            begin
               // first word names the source and so the flow queue to check against
               if (word_idx == 0)
               begin
                  src = int'(fab_out_data[d*W+W-1 -: PB]);
                  compare_value($sformatf("frame pending at output %0d from source %0d", d, src),
                                32'(rd_idx[src] < exp_q[src][d].size()), 32'(1));
                  frm = exp_q[src][d][rd_idx[src]];
               end
               compare_value($sformatf("output %0d sof", d),
                             32'(fab_out_sof[d]), 32'(word_idx == 0));
               compare_value($sformatf("output %0d data, source %0d frame %0d word %0d",
                                       d, src, frm, word_idx),
                             32'(fab_out_data[d*W +: W]), 32'(frm_word[src][frm][word_idx]));
               compare_value($sformatf("output %0d eof", d),
                             32'(fab_out_eof[d]), 32'(word_idx == frm_len[src][frm] - 1));
               if (fab_out_eof[d])
               begin
                  rd_idx[src]++;
                  word_idx = 0;
               end
               else
                  word_idx++;
            end
            drained = (word_idx == 0);
            for (int s = 0; s < N; s++)
               if (rd_idx[s] != exp_q[s][d].size())
                  drained = 1'b0;
         end
      end
   end

   // random back-pressure leaves each output ready about three cycles in four
   initial
   begin
      fab_out_ready = '1;
      forever
      begin
         @(posedge clk);
         #1;
         for (int d = 0; d < N; d++)
            fab_out_ready[d] = ($urandom % 4) != 0;
      end
   end

   // --------------------
   // main sequence
   // --------------------
   initial
   begin
      int cycles;
      void'($urandom(81));
      rst_n = 1'b0;
      for (int p = 0; p < N; p++)
      begin
         for (int i = 0; i < FRAMES; i++)
         begin
            frm_len[p][i]     = 1 + int'($urandom % MAXW);
            frm_gap[p][i]     = int'($urandom % 6);
            rsp_gap[p][i]     = int'($urandom % 24);
            frm_mask[p][i]    = N'($urandom);
            frm_drop[p][i]    = ($urandom % 8) == 0;
            frm_word[p][i][0] = {PB'(p), SW'(i)};
            for (int k = 1; k < MAXW; k++)
               frm_word[p][i][k] = W'($urandom);
            // dropped and empty-mask frames reach no output
            if (!frm_drop[p][i])
               for (int d = 0; d < N; d++)
                  if (frm_mask[p][i][d])
                     exp_q[p][d].push_back(i);
         end
      end

      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // idle state before any stimulus
      @(negedge clk);
      compare_value("fab_out_valid_o after reset", 32'(fab_out_valid), 32'(0));
      compare_value("fab_out_sof_o after reset", 32'(fab_out_sof), 32'(0));
      compare_value("fab_in_ready_o after reset", 32'(fab_in_ready), 32'({N{1'b1}}));
      compare_value("rtu_ready_o after reset", 32'(rtu_ready), 32'({N{1'b1}}));
      @(posedge clk);
      #1;
      start = 1'b1;

      cycles = 0;
      while (!((&frames_sent) && (&rsps_sent) && (&sink_drained)))
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 4 * TIMEOUT)
            fail_run("timeout while waiting for every expected frame to arrive");
      end

      // no stray word may follow the last expected frame
      repeat (50) @(posedge clk);
      @(negedge clk);
      compare_value("fab_out_valid_o after drain", 32'(fab_out_valid), 32'(0));
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
swc_pkg.sv
swc_fifo.sv
swc_input_block.sv
swc_xbar_arbiter.sv
swc_output_block.sv
swc_core.sv
tb_swc_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the switch core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_swc_core \
   -f verilog.f -o tb_swc_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_swc_core > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation returned status $run_status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
   exit 1
fi
exit 0
